// File: include/fdiv_r16_settings.svh
// Widths assume normalized mantissas of the form 1.f with the hidden one present
// The selector window is 7 bits wide, since 3 fraction bits of the estimate are needed
// for the 3-bit divisor index without prescaling
`ifndef FDIV_R16_SETTINGS_SVH
`define FDIV_R16_SETTINGS_SVH

// Mantissa fraction bits and full mantissa width with the hidden one
`define FDIV_FRAC_W 16
`define FDIV_MANT_W 17

// Remainder is 4 integer bits (sign and guards) plus 20 fraction bits
`define FDIV_REM_W 24

// Five radix-16 iterations give 20 raw quotient bits of x/(4d)
`define FDIV_ITER_N 5
`define FDIV_QUOT_RAW_W 20

// Remainder estimate width and divisor index width seen by the digit selector
`define FDIV_QDS_REM_W 7
`define FDIV_DIV_IDX_W 3

// 1 selects five speculative selectors for the second step
`define FDIV_SRT_2ND_SPEC 1

`endif

// File: logic/fdiv_r16_pkg.sv
// Shared types of the radix-16 mantissa divider
// Widths come from the settings header
`include "fdiv_r16_settings.svh"

package fdiv_r16_pkg;

	// One-hot quotient digit, bit order follows {n2, n1, z0, p1, p2}
	typedef enum logic [4:0] {
		DIG_N2 = 5'b10000,
		DIG_N1 = 5'b01000,
		DIG_Z0 = 5'b00100,
		DIG_P1 = 5'b00010,
		DIG_P2 = 5'b00001
	} quot_dig_e;

	// Carry-save remainder, value is (s + c) / 2^20 in two's complement
	typedef struct packed {
		logic [`FDIV_REM_W-1:0] s;
		logic [`FDIV_REM_W-1:0] c;
	} rem_cs_t;

	// Request payload, both operands are 1.f mantissas
	typedef struct packed {
		logic [`FDIV_MANT_W-1:0] dividend;
		logic [`FDIV_MANT_W-1:0] divisor;
	} fdiv_req_t;

	// Response payload, quot is floor(x * 2^16 / d)
	typedef struct packed {
		logic [`FDIV_MANT_W-1:0] quot;
		logic                    sticky;
	} fdiv_rsp_t;

	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_ITER = 2'd1,
		ST_FIX  = 2'd2,
		ST_DONE = 2'd3
	} fdiv_state_e;

endpackage

// File: logic/fdiv_r4_qds.sv
// Radix-4 digit selection for a divisor in [1, 2) without prescaling
// The estimate is the truncated carry-save sum of 4w in units of 1/8
`timescale 1ns/1ps
`include "fdiv_r16_settings.svh"

module fdiv_r4_qds (
	input  logic [`FDIV_QDS_REM_W-1:0] rem_i,
	input  logic [`FDIV_DIV_IDX_W-1:0] div_idx_i,
	output fdiv_r16_pkg::quot_dig_e    dig_o
);

	logic signed [`FDIV_QDS_REM_W-1:0] est;
	// Lower bounds for picking +2, +1, 0 and -1
	logic signed [`FDIV_QDS_REM_W-1:0] th_p2;
	logic signed [`FDIV_QDS_REM_W-1:0] th_p1;
	logic signed [`FDIV_QDS_REM_W-1:0] th_z0;
	logic signed [`FDIV_QDS_REM_W-1:0] th_n1;

	assign est = $signed(rem_i);

	// ==================================================
	// Threshold rows, one per divisor interval of width 1/8
	// Each value lies inside the P-D overlap region, widened by the
	// truncation error of the estimate and the interval width
	// ==================================================
	always_comb begin
		case (div_idx_i)
			3'd0: begin
				th_p2 = 7'sd12; th_p1 = 7'sd4; th_z0 = -7'sd4; th_n1 = -7'sd13;
			end
			3'd1: begin
				th_p2 = 7'sd14; th_p1 = 7'sd4; th_z0 = -7'sd5; th_n1 = -7'sd15;
			end
			3'd2: begin
				th_p2 = 7'sd15; th_p1 = 7'sd4; th_z0 = -7'sd6; th_n1 = -7'sd16;
			end
			3'd3: begin
				th_p2 = 7'sd16; th_p1 = 7'sd5; th_z0 = -7'sd6; th_n1 = -7'sd18;
			end
			3'd4: begin
				th_p2 = 7'sd18; th_p1 = 7'sd5; th_z0 = -7'sd7; th_n1 = -7'sd19;
			end
			3'd5: begin
				th_p2 = 7'sd19; th_p1 = 7'sd6; th_z0 = -7'sd7; th_n1 = -7'sd21;
			end
			3'd6: begin
				th_p2 = 7'sd20; th_p1 = 7'sd6; th_z0 = -7'sd8; th_n1 = -7'sd22;
			end
			default: begin
				th_p2 = 7'sd22; th_p1 = 7'sd7; th_z0 = -7'sd8; th_n1 = -7'sd24;
			end
		endcase
	end

	// Priority compare from the top, so exactly one digit is active
	always_comb begin
		if (est >= th_p2)
			dig_o = fdiv_r16_pkg::DIG_P2;
		else if (est >= th_p1)
			dig_o = fdiv_r16_pkg::DIG_P1;
		else if (est >= th_z0)
			dig_o = fdiv_r16_pkg::DIG_Z0;
		else if (est >= th_n1)
			dig_o = fdiv_r16_pkg::DIG_N1;
		else
			dig_o = fdiv_r16_pkg::DIG_N2;
	end

endmodule

// File: logic/fdiv_r16_block.sv
// Two chained radix-4 SRT steps per call in purely combinational logic
// The remainder must satisfy |w| <= 2d/3 on entry, which the caller guarantees
`timescale 1ns/1ps
`include "fdiv_r16_settings.svh"

module fdiv_r16_block #(
	parameter int SRT_2ND_SPEC = `FDIV_SRT_2ND_SPEC
) (
	input  fdiv_r16_pkg::rem_cs_t       rem_i,
	input  logic [`FDIV_MANT_W-1:0]     divisor_i,
	output fdiv_r16_pkg::rem_cs_t       rem_o,
	output fdiv_r16_pkg::quot_dig_e     dig_1st_o,
	output fdiv_r16_pkg::quot_dig_e     dig_2nd_o
);

	localparam int W = `FDIV_REM_W;
	localparam int E = `FDIV_QDS_REM_W;
	// Carry-in bit per digit position, set for the two positive digits
	localparam logic [4:0] CIN = 5'b00011;

	logic [W-1:0]                 div_x1;
	logic [W-1:0]                 div_x2;
	// Addend per digit position in the order of the one-hot digit bits
	logic [W-1:0]                 addend [5];
	logic [`FDIV_DIV_IDX_W-1:0]   div_idx;
	logic [E-1:0]                 est_1st;
	logic [E-1:0]                 est_2nd [5];
	fdiv_r16_pkg::rem_cs_t        cand_1st [5];
	fdiv_r16_pkg::rem_cs_t        cand_2nd [5];
	fdiv_r16_pkg::rem_cs_t        rem_1st;
	fdiv_r16_pkg::quot_dig_e      dig_1st;
	fdiv_r16_pkg::quot_dig_e      dig_2nd;

	// Scale the remainder by 4 and fold one addend in with a 3:2 compressor
	function automatic fdiv_r16_pkg::rem_cs_t csa_step(
		input fdiv_r16_pkg::rem_cs_t r,
		input logic [W-1:0]          add,
		input logic                  c_in
	);
		logic [W-1:0]          s_sh;
		logic [W-1:0]          c_sh;
		logic [W-1:0]          maj;
		fdiv_r16_pkg::rem_cs_t res;
		s_sh  = {r.s[W-3:0], 2'b00};
		c_sh  = {r.c[W-3:0], 2'b00};
		maj   = (s_sh & c_sh) | (s_sh & add) | (c_sh & add);
		res.s = s_sh ^ c_sh ^ add;
		// Carry-in completes the two's complement for positive digits
		res.c = {maj[W-2:0], c_in};
		return res;
	endfunction

	// ==================================================
	// Divisor multiples
	// ==================================================
	assign div_x1  = {{(W-`FDIV_MANT_W-4){1'b0}}, divisor_i, 4'b0000};
	assign div_x2  = {{(W-`FDIV_MANT_W-5){1'b0}}, divisor_i, 5'b00000};
	// Top fraction bits pick the threshold row
	assign div_idx = divisor_i[`FDIV_FRAC_W-1 -: `FDIV_DIV_IDX_W];

	// Negative digits add the multiple and positive digits subtract it
	assign addend[4] = div_x2;
	assign addend[3] = div_x1;
	assign addend[2] = '0;
	assign addend[1] = ~div_x1;
	assign addend[0] = ~div_x2;

	// ==================================================
	// First step
	// ==================================================
	// Estimate of 4w from the top bits of both words
	assign est_1st = rem_i.s[W-3 -: E] + rem_i.c[W-3 -: E];

	fdiv_r4_qds u_qds_1st (
		.rem_i     (est_1st),
		.div_idx_i (div_idx),
		.dig_o     (dig_1st)
	);

	always_comb begin
		rem_1st = '0;
		for (int i = 0; i < 5; i++) begin
			cand_1st[i] = csa_step(rem_i, addend[i], CIN[i]);
			// One second-step estimate per first-digit candidate
			est_2nd[i]  = cand_1st[i].s[W-3 -: E] + cand_1st[i].c[W-3 -: E];
			rem_1st     = rem_1st | ({(2*W){dig_1st[i]}} & cand_1st[i]);
		end
	end

	// ==================================================
	// Second step digit
	// ==================================================
	if (SRT_2ND_SPEC == 1) begin : g_spec
		fdiv_r16_pkg::quot_dig_e dig_spec [5];
		logic [4:0]              dig_mux;

		// Select a second digit for every possible first digit in parallel
		for (genvar g = 0; g < 5; g++) begin : g_qds
			fdiv_r4_qds u_qds_spec (
				.rem_i     (est_2nd[g]),
				.div_idx_i (div_idx),
				.dig_o     (dig_spec[g])
			);
		end

		always_comb begin
			dig_mux = '0;
			for (int i = 0; i < 5; i++)
				dig_mux = dig_mux | ({5{dig_1st[i]}} & dig_spec[i]);
		end
		assign dig_2nd = fdiv_r16_pkg::quot_dig_e'(dig_mux);
	end else begin : g_nospec
		logic [E-1:0] est_sel;

		// Pick the estimate first, then run a single selector
		always_comb begin
			est_sel = '0;
			for (int i = 0; i < 5; i++)
				est_sel = est_sel | ({E{dig_1st[i]}} & est_2nd[i]);
		end

		fdiv_r4_qds u_qds_2nd (
			.rem_i     (est_sel),
			.div_idx_i (div_idx),
			.dig_o     (dig_2nd)
		);
	end

	// ==================================================
	// Second step remainder
	// ==================================================
	always_comb begin
		rem_o = '0;
		for (int i = 0; i < 5; i++) begin
			cand_2nd[i] = csa_step(rem_1st, addend[i], CIN[i]);
			rem_o       = rem_o | ({(2*W){dig_2nd[i]}} & cand_2nd[i]);
		end
	end

	assign dig_1st_o = dig_1st;
	assign dig_2nd_o = dig_2nd;

endmodule

// File: logic/fdiv_otf_conv.sv
// On-the-fly conversion of two radix-4 digits per step into Q and QM = Q - 1
// Load clears both registers, which is safe since the first digit is always positive
`timescale 1ns/1ps
`include "fdiv_r16_settings.svh"

module fdiv_otf_conv (
	input  logic                           clk_i,
	input  logic                           rst_n_i,
	input  logic                           load_i,
	input  logic                           step_i,
	input  fdiv_r16_pkg::quot_dig_e        dig_1st_i,
	input  fdiv_r16_pkg::quot_dig_e        dig_2nd_i,
	output logic [`FDIV_QUOT_RAW_W-1:0]    q_o,
	output logic [`FDIV_QUOT_RAW_W-1:0]    qm_o
);

	localparam int QW = `FDIV_QUOT_RAW_W;

	logic [QW-1:0] q_r;
	logic [QW-1:0] qm_r;
	logic [QW-1:0] q_mid;
	logic [QW-1:0] qm_mid;
	logic [QW-1:0] q_nxt;
	logic [QW-1:0] qm_nxt;

	// Append one digit, returns {Q, QM}
	function automatic logic [2*QW-1:0] otf_digit(
		input logic [QW-1:0]         q,
		input logic [QW-1:0]         qm,
		input fdiv_r16_pkg::quot_dig_e dig
	);
		logic [QW-3:0] qh;
		logic [QW-3:0] qmh;
		qh  = q[QW-3:0];
		qmh = qm[QW-3:0];
		case (dig)
			fdiv_r16_pkg::DIG_P2: return {qh, 2'd2, qh, 2'd1};
			fdiv_r16_pkg::DIG_P1: return {qh, 2'd1, qh, 2'd0};
			fdiv_r16_pkg::DIG_Z0: return {qh, 2'd0, qmh, 2'd3};
			// Negative digits borrow from QM instead of subtracting from Q
			fdiv_r16_pkg::DIG_N1: return {qmh, 2'd3, qmh, 2'd2};
			default:              return {qmh, 2'd2, qmh, 2'd1};
		endcase
	endfunction

	assign {q_mid, qm_mid} = otf_digit(q_r, qm_r, dig_1st_i);
	assign {q_nxt, qm_nxt} = otf_digit(q_mid, qm_mid, dig_2nd_i);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			q_r  <= '0;
			qm_r <= '0;
		end else if (load_i) begin
			q_r  <= '0;
			qm_r <= '0;
		end else if (step_i) begin
			q_r  <= q_nxt;
			qm_r <= qm_nxt;
		end
	end

	assign q_o  = q_r;
	assign qm_o = qm_r;

endmodule

// File: logic/fdiv_r16_top.sv
// One division in flight, the response comes ITER_N + 2 cycles after acceptance
// counting the accepting cycle, operands must be normalized 1.f mantissas
`timescale 1ns/1ps
`include "fdiv_r16_settings.svh"

module fdiv_r16_top (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  logic                     req_valid_i,
	output logic                     req_ready_o,
	input  fdiv_r16_pkg::fdiv_req_t  req_i,
	output logic                     rsp_valid_o,
	input  logic                     rsp_ready_i,
	output fdiv_r16_pkg::fdiv_rsp_t  rsp_o
);

	localparam int W     = `FDIV_REM_W;
	localparam int CNT_W = $clog2(`FDIV_ITER_N);

	fdiv_r16_pkg::fdiv_state_e       state;
	logic [CNT_W-1:0]                iter_cnt;
	logic                            accept;
	fdiv_r16_pkg::rem_cs_t           rem_q;
	fdiv_r16_pkg::rem_cs_t           rem_nxt;
	logic [`FDIV_MANT_W-1:0]         div_q;
	fdiv_r16_pkg::quot_dig_e         dig_1st;
	fdiv_r16_pkg::quot_dig_e         dig_2nd;
	logic [`FDIV_QUOT_RAW_W-1:0]     quot_q;
	logic [`FDIV_QUOT_RAW_W-1:0]     quot_qm;
	logic [`FDIV_QUOT_RAW_W-1:0]     quot_sel;
	logic [W-1:0]                    rem_sum;
	logic [W-1:0]                    rem_fix;
	logic                            rem_neg;
	logic                            rem_nz;
	fdiv_r16_pkg::fdiv_rsp_t         rsp_q;

	assign req_ready_o = (state == fdiv_r16_pkg::ST_IDLE);
	assign accept      = req_valid_i & req_ready_o;
	assign rsp_valid_o = (state == fdiv_r16_pkg::ST_DONE);

	// ==================================================
	// Control FSM
	// ==================================================
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state    <= fdiv_r16_pkg::ST_IDLE;
			iter_cnt <= '0;
		end else begin
			case (state)
				fdiv_r16_pkg::ST_IDLE: begin
					iter_cnt <= '0;
					if (accept)
						state <= fdiv_r16_pkg::ST_ITER;
				end
				fdiv_r16_pkg::ST_ITER: begin
					// Exactly ITER_N radix-16 iterations
					if (iter_cnt == CNT_W'(`FDIV_ITER_N - 1))
						state <= fdiv_r16_pkg::ST_FIX;
					iter_cnt <= iter_cnt + 1'b1;
				end
				fdiv_r16_pkg::ST_FIX: state <= fdiv_r16_pkg::ST_DONE;
				default: begin
					// Hold the response until the consumer takes it
					if (rsp_ready_i)
						state <= fdiv_r16_pkg::ST_IDLE;
				end
			endcase
		end
	end

	// ==================================================
	// Remainder and divisor registers
	// ==================================================
	// Initial remainder is x/4, so |w| <= 2d/3 holds from the start
	always_ff @(posedge clk_i) begin
		if (accept) begin
			rem_q.s <= {{(W-`FDIV_MANT_W-2){1'b0}}, req_i.dividend, 2'b00};
			rem_q.c <= '0;
			div_q   <= req_i.divisor;
		end else if (state == fdiv_r16_pkg::ST_ITER) begin
			rem_q   <= rem_nxt;
		end
	end

	fdiv_r16_block #(
		.SRT_2ND_SPEC (`FDIV_SRT_2ND_SPEC)
	) u_block (
		.rem_i     (rem_q),
		.divisor_i (div_q),
		.rem_o     (rem_nxt),
		.dig_1st_o (dig_1st),
		.dig_2nd_o (dig_2nd)
	);

	fdiv_otf_conv u_conv (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.load_i    (accept),
		.step_i    (state == fdiv_r16_pkg::ST_ITER),
		.dig_1st_i (dig_1st),
		.dig_2nd_i (dig_2nd),
		.q_o       (quot_q),
		.qm_o      (quot_qm)
	);

	// ==================================================
	// Final correction
	// ==================================================
	assign rem_sum  = rem_q.s + rem_q.c;
	assign rem_neg  = rem_sum[W-1];
	// A negative remainder is restored by one divisor and the quotient drops by one
	assign rem_fix  = rem_sum + {{(W-`FDIV_MANT_W-4){1'b0}}, div_q, 4'b0000};
	assign rem_nz   = rem_neg ? (|rem_fix) : (|rem_sum);
	assign quot_sel = rem_neg ? quot_qm : quot_q;

	// Raw quotient is x/(4d) with 20 fraction bits, bits 18..2 give x*2^16/d
	always_ff @(posedge clk_i) begin
		if (state == fdiv_r16_pkg::ST_FIX) begin
			rsp_q.quot   <= quot_sel[`FDIV_FRAC_W+2:2];
			rsp_q.sticky <= rem_nz | (|quot_sel[1:0]);
		end
	end

	assign rsp_o = rsp_q;

endmodule

// File: test/fdiv_r16_assert.sv
// Concurrent checks bound into every fdiv_r16_top instance
// Digit legality is only checked while iterating, when the remainder register is loaded
`timescale 1ns/1ps
`include "fdiv_r16_settings.svh"

module fdiv_r16_assert (
	input logic                      clk_i,
	input logic                      rst_n_i,
	input logic                      req_valid_i,
	input logic                      req_ready_i,
	input logic                      rsp_valid_i,
	input logic                      rsp_ready_i,
	input fdiv_r16_pkg::fdiv_rsp_t   rsp_i,
	input fdiv_r16_pkg::fdiv_state_e state_i,
	input fdiv_r16_pkg::quot_dig_e   dig_1st_i,
	input fdiv_r16_pkg::quot_dig_e   dig_2nd_i
);

	// Number of failed assertions seen so far
	int fail_cnt = 0;

	// No new request may be taken while a division is in flight
	// The busy window spans the iterations, the fix cycle and the first response cycle
	a_ready_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(req_valid_i && req_ready_i) |=> !req_ready_i [*(`FDIV_ITER_N + 2)])
		else begin
			$error("req_ready_o is high while the divider is busy");
			fail_cnt++;
		end

	// A pending response keeps its valid and its payload
	a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(rsp_valid_i && !rsp_ready_i) |=> (rsp_valid_i && $stable(rsp_i)))
		else begin
			$error("response dropped or changed under back-pressure");
			fail_cnt++;
		end

	// Each selector must return exactly one digit
	a_dig_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(state_i == fdiv_r16_pkg::ST_ITER) |-> ($onehot(dig_1st_i) && $onehot(dig_2nd_i)))
		else begin
			$error("quotient digit is not one-hot");
			fail_cnt++;
		end

endmodule

bind fdiv_r16_top fdiv_r16_assert u_assert (
	.clk_i       (clk_i),
	.rst_n_i     (rst_n_i),
	.req_valid_i (req_valid_i),
	.req_ready_i (req_ready_o),
	.rsp_valid_i (rsp_valid_o),
	.rsp_ready_i (rsp_ready_i),
	.rsp_i       (rsp_o),
	.state_i     (state),
	.dig_1st_i   (dig_1st),
	.dig_2nd_i   (dig_2nd)
);

// File: test/fdiv_r16_tb.sv
// Random 1.f operands come from an LCG with seed 75 and are checked against a wide integer model
// Latency is counted in rising edges with the accepting edge as edge one
`timescale 1ns/1ps
`include "fdiv_r16_settings.svh"

module fdiv_r16_tb;

	localparam int WAIT_LIMIT = 50;
	localparam int RAND_N     = 200;

	logic                     clk_i;
	logic                     rst_n_i;
	logic                     req_valid_i;
	logic                     req_ready_o;
	fdiv_r16_pkg::fdiv_req_t  req_i;
	logic                     rsp_valid_o;
	logic                     rsp_ready_i;
	fdiv_r16_pkg::fdiv_rsp_t  rsp_o;

	logic [31:0] lcg_state;
	int          err_cnt;
	int          pass_tests;
	int          fail_tests;

	fdiv_r16_top u_dut (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.req_valid_i (req_valid_i),
		.req_ready_o (req_ready_o),
		.req_i       (req_i),
		.rsp_valid_o (rsp_valid_o),
		.rsp_ready_i (rsp_ready_i),
		.rsp_o       (rsp_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	// LCG step that returns the upper half of the state, which has the better randomness
	function automatic logic [15:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[31:16];
	endfunction

	task automatic check_val(input string name, input logic [63:0] exp_v,
		input logic [63:0] act_v);
		if (exp_v !== act_v) begin
			$display("** Error %s: expected %0d, actual %0d", name, exp_v, act_v);
			err_cnt++;
		end
	endtask

	// Print one line per finished test and judge it by the errors it added
	task automatic end_test(input string name, input int err_before);
		if (err_cnt == err_before) begin
			pass_tests++;
			$display("PASS %s", name);
		end else begin
			fail_tests++;
			$display("FAIL %s", name);
		end
	endtask

	// ==================================================
	// One division with the response held back for hold cycles
	// ==================================================
	task automatic run_div(input string name, input logic [16:0] x, input logic [16:0] d,
		input int hold);
		logic [63:0]             num;
		logic [16:0]             exp_q;
		logic                    exp_s;
		int                      waited;
		int                      edges;
		fdiv_r16_pkg::fdiv_rsp_t first_rsp;
		int                      err_before;
		err_before = err_cnt;
		// The model quotient is floor(x * 2^16 / d) and sticky marks a nonzero remainder
		num   = {47'd0, x} << `FDIV_FRAC_W;
		exp_q = num / d;
		exp_s = (num % d) != 0;
		@(posedge clk_i);
		req_valid_i    <= 1'b1;
		req_i.dividend <= x;
		req_i.divisor  <= d;
		waited = 0;
		@(negedge clk_i);
		while (!req_ready_o && waited < WAIT_LIMIT) begin
			@(negedge clk_i);
			waited++;
		end
		if (!req_ready_o) begin
			$display("%s: the DUT never became ready for the request", name);
			err_cnt++;
			@(posedge clk_i);
			req_valid_i <= 1'b0;
		end else begin
			// This edge takes the request
			@(posedge clk_i);
			req_valid_i <= 1'b0;
			edges = 1;
			@(negedge clk_i);
			while (!rsp_valid_o && edges < WAIT_LIMIT) begin
				@(posedge clk_i);
				edges++;
				@(negedge clk_i);
			end
			if (!rsp_valid_o) begin
				$display("%s: no response arrived within %0d cycles", name, WAIT_LIMIT);
				err_cnt++;
			end else begin
				check_val({name, " latency"}, `FDIV_ITER_N + 2, edges);
				first_rsp = rsp_o;
				for (int i = 0; i < hold; i++) begin
					@(posedge clk_i);
					@(negedge clk_i);
					check_val({name, " valid held"}, 1, rsp_valid_o);
					check_val({name, " ready low"}, 0, req_ready_o);
					check_val({name, " response stable"}, first_rsp, rsp_o);
				end
				check_val({name, " quotient"}, exp_q, rsp_o.quot);
				check_val({name, " sticky"}, exp_s, rsp_o.sticky);
				@(posedge clk_i);
				rsp_ready_i <= 1'b1;
				// Response transfer happens on this edge
				@(posedge clk_i);
				rsp_ready_i <= 1'b0;
			end
		end
		end_test(name, err_before);
	endtask

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin
		int          err_before;
		logic [16:0] x;
		logic [16:0] d;
		rst_n_i     = 1'b0;
		req_valid_i = 1'b0;
		rsp_ready_i = 1'b0;
		req_i       = '0;
		lcg_state   = 32'd75;
		err_cnt     = 0;
		pass_tests  = 0;
		fail_tests  = 0;
		repeat (2) @(posedge clk_i);
		rst_n_i <= 1'b1;

		err_before = err_cnt;
		@(negedge clk_i);
		check_val("reset rsp_valid", 0, rsp_valid_o);
		check_val("reset req_ready", 1, req_ready_o);
		end_test("reset", err_before);

		// Corner operands first
		run_div("equal min", 17'h10000, 17'h10000, 0);
		run_div("equal max", 17'h1FFFF, 17'h1FFFF, 0);
		x = {1'b1, next_rand()};
		run_div("equal random", x, x, 0);
		run_div("divisor one max", 17'h1FFFF, 17'h10000, 0);
		x = {1'b1, next_rand()};
		run_div("divisor one random", x, 17'h10000, 0);

		for (int i = 0; i < RAND_N; i++) begin
			x = {1'b1, next_rand()};
			d = {1'b1, next_rand()};
			run_div($sformatf("random %0d", i), x, d, 0);
		end

		// Back-pressure with a random stall length
		for (int i = 0; i < 5; i++) begin
			x = {1'b1, next_rand()};
			d = {1'b1, next_rand()};
			run_div($sformatf("backpressure %0d", i), x, d, (next_rand() % 8) + 1);
		end

		$display("Summary: %0d tests, %0d passed, %0d failed, %0d errors, %0d assert fails",
			pass_tests + fail_tests, pass_tests, fail_tests, err_cnt,
			u_dut.u_assert.fail_cnt);
		if (err_cnt == 0 && fail_tests == 0 && u_dut.u_assert.fail_cnt == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: fdiv_r16.f
+incdir+include
logic/fdiv_r16_pkg.sv
logic/fdiv_r4_qds.sv
logic/fdiv_r16_block.sv
logic/fdiv_otf_conv.sv
logic/fdiv_r16_top.sv
test/fdiv_r16_assert.sv
test/fdiv_r16_tb.sv
